//--- source/wfd_settings.svh
// shared constants for the wfd readout core, included by every rtl file that needs them
`ifndef WFD_SETTINGS_SVH
`define WFD_SETTINGS_SVH

// trigger fanout
`define WFD_NUM_CHAN 5             // channel fpga trigger lines
`define WFD_TRIG_WIDTH_DEFAULT 4   // pulse length after reset, in clk125 cycles

// daq framing
`define WFD_HEADER_TAG 32'h00005a57 // low half of every header word

// ipbus register map, word addresses
`define WFD_ADDR_CTRL   24'h000000 // bit 0 fires a trigger, self clearing
`define WFD_ADDR_WIDTH  24'h000001 // trigger width, 4 bits
`define WFD_ADDR_TRIGS  24'h000002 // trigger writes seen
`define WFD_ADDR_EVENTS 24'h000003 // completed events
`define WFD_ADDR_STATUS 24'h000004 // bit 0 busy, bit 1 daq_ready

`endif

//--- source/wfd_pkg.sv
// types shared by the readout rtl and its testbench, compiled ahead of every importing module
package wfd_pkg;

    // readout sequencer states
    typedef enum logic [2:0] {
        IDLE,    // waiting for a software trigger
        FIRE,    // one cycle, trigger pulse starts
        HEADER,  // header held off by almost_full
        DATA,    // channel beats packed into daq words
        TRAILER  // closing word with beat count
    } readout_state_t;

    // command from sequencer to packer, one per cycle
    typedef enum logic [1:0] {
        PK_NONE,
        PK_HEADER,
        PK_DATA,
        PK_TRAILER
    } pack_op_t;

    // one beat of the channel axi stream
    typedef struct packed {
        logic [31:0] tdata;
        logic        tlast; // final beat of the event
    } chan_beat_t;

    // one word toward the amc13 daq link
    typedef struct packed {
        logic [63:0] data;
        logic        header;  // first word of an event
        logic        trailer; // last word of an event
    } daq_word_t;

endpackage

//--- source/wfd_regs.sv
// ipbus register slave for trigger control and readout status, instantiated once in wfd_top
`timescale 1ns/100ps
`include "wfd_settings.svh"

module wfd_regs (
    input  logic        clk125,
    input  logic        reset,
    input  logic        ipb_strobe,
    input  logic        ipb_write,
    input  logic [23:0] ipb_addr,
    input  logic [31:0] ipb_wdata,
    output logic [31:0] ipb_rdata,
    output logic        ipb_ack,
    input  logic        busy,        // readout sequencer not idle
    input  logic        daq_ready,   // daq link is up
    input  logic [31:0] event_count, // completed events from readout_fsm
    output logic        trig_req,    // one cycle, same edge as ack
    output logic [3:0]  trig_width   // trigger pulse length, never 0
);
    logic        access;     // first strobe cycle of a transfer
    logic        trig_write; // software trigger in this access
    logic        width_write;
    logic [3:0]  width_reg;
    logic [31:0] trig_count;
    logic [31:0] read_mux;

    // master holds strobe through the ack cycle, so mask it there
    assign access      = ipb_strobe & ~ipb_ack;
    assign trig_write  = access & ipb_write & (ipb_addr == `WFD_ADDR_CTRL) & ipb_wdata[0];
    assign width_write = access & ipb_write & (ipb_addr == `WFD_ADDR_WIDTH);
    assign trig_width  = width_reg;

    // read decode
    always_comb begin
        case (ipb_addr)
            `WFD_ADDR_WIDTH:  read_mux = {28'd0, width_reg};
            `WFD_ADDR_TRIGS:  read_mux = trig_count;
            `WFD_ADDR_EVENTS: read_mux = event_count;
            `WFD_ADDR_STATUS: read_mux = {30'd0, daq_ready, busy};
            default:          read_mux = 32'd0; // ctrl reads back 0, as do holes in the map
        endcase
    end

    always_ff @(posedge clk125) begin
        if (reset) begin
            ipb_ack    <= 1'b0;
            trig_req   <= 1'b0;
            width_reg  <= 4'(`WFD_TRIG_WIDTH_DEFAULT);
            trig_count <= 32'd0;
        end else begin
            ipb_ack  <= access;     // single cycle ack, one after the first strobe
            trig_req <= trig_write; // self clearing
            if (trig_write) begin
                trig_count <= trig_count + 32'd1; // counted even if the sequencer drops it
            end
            if (width_write) begin
                // zero would give no pulse at all, so clamp to one cycle
                width_reg <= (ipb_wdata[3:0] == 4'd0) ? 4'd1 : ipb_wdata[3:0];
            end
        end
    end

    // read data, valid in the ack cycle
    always_ff @(posedge clk125) begin
        if (access & ~ipb_write) begin
            ipb_rdata <= read_mux;
        end
    end

endmodule

//--- source/trigger_fanout.sv
// stretches the one-cycle fire strobe into a programmable pulse on every channel trigger line
`timescale 1ns/100ps
`include "wfd_settings.svh"

module trigger_fanout (
    input  logic                     clk125,
    input  logic                     reset,
    input  logic                     fire,       // one cycle from readout_fsm
    input  logic [3:0]               trig_width, // pulse length in cycles, 1 to 15
    output logic [`WFD_NUM_CHAN-1:0] acq_trigs   // to the channel fpgas
);
    logic [3:0] count; // cycles of pulse left

    always_ff @(posedge clk125) begin
        if (reset) begin
            count <= 4'd0;
        end else if (fire) begin
            count <= trig_width; // a new fire restarts the pulse
        end else if (count != 4'd0) begin
            count <= count - 4'd1;
        end
    end

    // all channels see the same pulse
    assign acq_trigs = {`WFD_NUM_CHAN{count != 4'd0}};

endmodule

//--- source/readout_fsm.sv
// readout sequencer that takes triggers, steps the packer through one event and counts events
`timescale 1ns/100ps

module readout_fsm (
    input  logic              clk125,
    input  logic              reset,
    input  logic              trig_req,        // software trigger from wfd_regs
    input  logic              daq_ready,       // link up, else triggers are dropped
    input  logic              daq_almost_full, // hold off header and trailer
    input  logic              beat_last,       // packer took the tlast beat
    output logic              fire,            // starts the trigger pulse
    output wfd_pkg::pack_op_t pack_op,         // word request to daq_packer
    output logic [31:0]       event_num,       // header number and software count
    output logic              busy
);
    import wfd_pkg::*;

    readout_state_t state;
    readout_state_t next_state;
    logic [31:0]    event_count;
    logic           trailer_sent;

    always_ff @(posedge clk125) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // next state and packer command
    always_comb begin
        next_state = state;
        pack_op    = PK_NONE;
        case (state)
            IDLE: begin
                if (trig_req & daq_ready) begin
                    next_state = FIRE; // otherwise the request is lost
                end
            end
            FIRE: begin
                // header goes out alongside the pulse start when the link has room
                if (!daq_almost_full) begin
                    pack_op    = PK_HEADER;
                    next_state = DATA;
                end else begin
                    next_state = HEADER;
                end
            end
            HEADER: begin
                if (!daq_almost_full) begin
                    pack_op    = PK_HEADER;
                    next_state = DATA;
                end
            end
            DATA: begin
                pack_op = PK_DATA; // packer gates ready with almost_full itself
                if (beat_last) begin
                    next_state = TRAILER;
                end
            end
            TRAILER: begin
                if (!daq_almost_full) begin
                    pack_op    = PK_TRAILER;
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    assign trailer_sent = (state == TRAILER) & ~daq_almost_full;

    // event counter, bumps on the trailer edge
    always_ff @(posedge clk125) begin
        if (reset) begin
            event_count <= 32'd0;
        end else if (trailer_sent) begin
            event_count <= event_count + 32'd1;
        end
    end

    assign fire      = (state == FIRE);
    assign busy      = (state != IDLE);
    assign event_num = event_count; // header and trailer carry the pre-increment value

endmodule

//--- source/daq_packer.sv
// packs 32-bit channel beats into framed 64-bit daq words under command of readout_fsm
`timescale 1ns/100ps
`include "wfd_settings.svh"

module daq_packer (
    input  logic                clk125,
    input  logic                reset,
    input  wfd_pkg::pack_op_t   pack_op,
    input  logic [31:0]         event_num,
    input  logic                daq_almost_full,
    input  wfd_pkg::chan_beat_t chan_rx,
    input  logic                chan_rx_valid,
    output logic                chan_rx_ready,
    output wfd_pkg::daq_word_t  daq_out,
    output logic                daq_valid,
    output logic                beat_last // tlast beat taken this cycle
);
    import wfd_pkg::*;

    logic        accept;     // beat transfer this cycle
    logic        have_hi;    // first beat of a pair is waiting
    logic [31:0] hi_word;
    logic [31:0] beat_count; // beats of the current event
    daq_word_t   next_word;
    logic        next_valid;

    assign chan_rx_ready = (pack_op == PK_DATA) & ~daq_almost_full;
    assign accept        = chan_rx_valid & chan_rx_ready;
    assign beat_last     = accept & chan_rx.tlast;

    // word builder
    always_comb begin
        next_word  = '0;
        next_valid = 1'b0;
        case (pack_op)
            PK_HEADER: begin
                next_word.data   = {event_num, `WFD_HEADER_TAG};
                next_word.header = 1'b1;
                next_valid       = ~daq_almost_full;
            end
            PK_DATA: begin
                if (have_hi) begin
                    next_word.data = {hi_word, chan_rx.tdata}; // first beat in the high half
                end else begin
                    next_word.data = {chan_rx.tdata, 32'd0};   // odd final beat, zero pad
                end
                next_valid = accept & (have_hi | chan_rx.tlast);
            end
            PK_TRAILER: begin
                next_word.data    = {event_num, beat_count};
                next_word.trailer = 1'b1;
                next_valid        = ~daq_almost_full;
            end
            default: next_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk125) begin
        if (reset) begin
            daq_valid  <= 1'b0;
            have_hi    <= 1'b0;
            beat_count <= 32'd0;
        end else begin
            daq_valid <= next_valid;
            if (pack_op == PK_HEADER) begin
                have_hi    <= 1'b0;  // fresh event
                beat_count <= 32'd0;
            end else if (accept) begin
                have_hi    <= ~have_hi & ~chan_rx.tlast;
                beat_count <= beat_count + 32'd1;
            end
        end
    end

    // payload
    always_ff @(posedge clk125) begin
        if (next_valid) begin
            daq_out <= next_word;
        end
        if (accept & ~have_hi) begin
            hi_word <= chan_rx.tdata;
        end
    end

endmodule

//--- source/wfd_top.sv
// top level of the readout core, wiring register slave, trigger fanout, sequencer and packer
`timescale 1ns/100ps
`include "wfd_settings.svh"

module wfd_top (
    input  logic                     clk125, // whole core runs here
    input  logic                     reset,
    // ipbus slave
    input  logic                     ipb_strobe,
    input  logic                     ipb_write,
    input  logic [23:0]              ipb_addr,
    input  logic [31:0]              ipb_wdata,
    output logic [31:0]              ipb_rdata,
    output logic                     ipb_ack,
    // channel stream in
    input  wfd_pkg::chan_beat_t      chan_rx,
    input  logic                     chan_rx_valid,
    output logic                     chan_rx_ready,
    // amc13 daq link
    output wfd_pkg::daq_word_t       daq_out,
    output logic                     daq_valid,
    input  logic                     daq_ready,
    input  logic                     daq_almost_full,
    // triggers to channel fpgas
    output logic [`WFD_NUM_CHAN-1:0] acq_trigs
);
    import wfd_pkg::*;

    logic        trig_req;   // regs to sequencer
    logic        fire;       // sequencer to fanout
    logic        busy;
    logic        beat_last;  // packer back to sequencer
    logic [3:0]  trig_width;
    logic [31:0] event_num;
    pack_op_t    pack_op;

    wfd_regs regs (
        .clk125      (clk125),
        .reset       (reset),
        .ipb_strobe  (ipb_strobe),
        .ipb_write   (ipb_write),
        .ipb_addr    (ipb_addr),
        .ipb_wdata   (ipb_wdata),
        .ipb_rdata   (ipb_rdata),
        .ipb_ack     (ipb_ack),
        .busy        (busy),
        .daq_ready   (daq_ready),
        .event_count (event_num), // software reads the same counter
        .trig_req    (trig_req),
        .trig_width  (trig_width)
    );

    trigger_fanout ct (
        .clk125     (clk125),
        .reset      (reset),
        .fire       (fire),
        .trig_width (trig_width),
        .acq_trigs  (acq_trigs)
    );

    readout_fsm seq (
        .clk125          (clk125),
        .reset           (reset),
        .trig_req        (trig_req),
        .daq_ready       (daq_ready),
        .daq_almost_full (daq_almost_full),
        .beat_last       (beat_last),
        .fire            (fire),
        .pack_op         (pack_op),
        .event_num       (event_num),
        .busy            (busy)
    );

    daq_packer pack (
        .clk125          (clk125),
        .reset           (reset),
        .pack_op         (pack_op),
        .event_num       (event_num),
        .daq_almost_full (daq_almost_full),
        .chan_rx         (chan_rx),
        .chan_rx_valid   (chan_rx_valid),
        .chan_rx_ready   (chan_rx_ready),
        .daq_out         (daq_out),
        .daq_valid       (daq_valid),
        .beat_last       (beat_last)
    );

endmodule

//--- test/wfd_checker.sv
// monitor for the readout core testbench, rebuilds each event from accepted beats and compares
`timescale 1ns/100ps
`include "wfd_settings.svh"

module wfd_checker (
    input  logic                     clk125,
    input  logic                     reset,
    input  logic                     ipb_strobe,
    input  logic                     ipb_write,
    input  logic [23:0]              ipb_addr,
    input  logic [31:0]              ipb_wdata,
    input  logic                     ipb_ack,
    input  wfd_pkg::chan_beat_t      chan_rx,
    input  logic                     chan_rx_valid,
    input  logic                     chan_rx_ready,
    input  wfd_pkg::daq_word_t       daq_out,
    input  logic                     daq_valid,
    input  logic                     daq_almost_full,
    input  logic [`WFD_NUM_CHAN-1:0] acq_trigs
);
    import wfd_pkg::*;

    string       test_name = "startup";
    int          value_errors = 0;
    int          other_errors = 0;
    int          events_seen = 0; // trailers seen, also the next expected event number
    int          cyc = 0;         // negedge count
    int          pulse_start = 0;
    int          pulse_end = 0;
    bit          arm_accept = 0;  // next trigger ack should start a pulse
    int          arm_width = 0;
    bit          af_last = 0;     // almost_full one cycle back, gates the word now on daq_out
    logic [31:0] beats [0:15];    // accepted beats of the open event
    int          nbeats = 0;
    daq_word_t   words [0:15];    // daq words of the open event
    int          nwords = 0;

    task set_test(input string name);
        test_name = name;
    endtask

    task arm_trigger(input bit accept, input int width);
        arm_accept = accept;
        arm_width  = width;
    endtask

    task check_value(input string what, input logic [65:0] exp, input logic [65:0] act);
        if (exp !== act) begin
            value_errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task report_problem(input string msg);
        other_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    // expected word idx of an event with n beats
    function automatic daq_word_t ref_word(input int idx, input int n, input logic [31:0] evt);
        daq_word_t w;
        int        pairs;
        w     = '0;
        pairs = (n + 1) / 2;
        if (idx == 0) begin
            w.data   = {evt, `WFD_HEADER_TAG};
            w.header = 1'b1;
        end else if (idx == pairs + 1) begin
            w.data    = {evt, 32'(n)}; // beat count in the low half
            w.trailer = 1'b1;
        end else begin
            w.data[63:32] = beats[2*idx-2];                             // first beat high
            w.data[31:0]  = (2*idx - 1 < n) ? beats[2*idx-1] : 32'd0;   // odd tail padded
        end
        return w;
    endfunction

    task compare_event();
        int i;
        if (nwords != (nbeats + 1) / 2 + 2) begin
            report_problem($sformatf("event %0d has %0d words for %0d beats",
                                     events_seen, nwords, nbeats));
        end else begin
            for (i = 0; i < nwords; i++) begin
                check_value($sformatf("event %0d word %0d", events_seen, i),
                            ref_word(i, nbeats, 32'(events_seen)), words[i]);
            end
        end
    endtask

    // outputs are sampled mid cycle, away from the drive edge
    always @(negedge clk125) begin
        cyc++;
        if (reset && (ipb_ack !== 1'b0 || daq_valid !== 1'b0 || chan_rx_ready !== 1'b0
                      || acq_trigs !== '0)) begin
            report_problem("an output is not low during reset");
        end
        check_value("acq_trigs", {(`WFD_NUM_CHAN){cyc >= pulse_start && cyc < pulse_end}},
                    acq_trigs);
        if (ipb_ack === 1'b1 && !ipb_strobe) begin
            report_problem("ack seen without a strobe");
        end
        if (ipb_ack && ipb_write && ipb_addr == `WFD_ADDR_CTRL && ipb_wdata[0] && arm_accept) begin
            pulse_start = cyc + 2; // pulse starts two edges after the ack edge
            pulse_end   = pulse_start + arm_width;
            arm_accept  = 0;
        end
        if (daq_almost_full && chan_rx_ready) begin
            report_problem("chan_rx_ready is high while almost_full is high");
        end
        if (af_last && daq_valid === 1'b1) begin
            report_problem("a daq word was issued while almost_full was high");
        end
        af_last = daq_almost_full;
        if (chan_rx_valid && chan_rx_ready) begin // transfers at the coming edge
            if (nbeats < 16) beats[nbeats] = chan_rx.tdata;
            nbeats++;
        end
        if (daq_valid !== 1'b0) begin
            if (daq_valid !== 1'b1) begin
                report_problem("daq_valid is unknown");
            end else if (daq_out.header && nwords != 0) begin
                report_problem("header arrived inside an open event");
            end else if (!daq_out.header && nwords == 0) begin
                report_problem("daq word arrived outside an event");
            end else begin
                if (nwords < 16) words[nwords] = daq_out;
                nwords++;
                if (daq_out.trailer) begin
                    compare_event();
                    events_seen++;
                    nwords = 0;
                    nbeats = 0;
                end
            end
        end
    end

endmodule

//--- test/tb_wfd_top.sv
// testbench for wfd_top, drives ipbus, channel beats and daq flow control, checks via wfd_checker
`timescale 1ns/100ps
`include "wfd_settings.svh"

module tb_wfd_top;
    import wfd_pkg::*;

    localparam int NUM_EVENTS = 12;

    logic                     clk125 = 1'b0;
    logic                     reset;
    logic                     ipb_strobe;
    logic                     ipb_write;
    logic [23:0]              ipb_addr;
    logic [31:0]              ipb_wdata;
    logic [31:0]              ipb_rdata;
    logic                     ipb_ack;
    chan_beat_t               chan_rx;
    logic                     chan_rx_valid;
    logic                     chan_rx_ready;
    daq_word_t                daq_out;
    logic                     daq_valid;
    logic                     daq_ready;
    logic                     daq_almost_full;
    logic [`WFD_NUM_CHAN-1:0] acq_trigs;

    logic [31:0] rng;          // stimulus lcg state
    logic [31:0] af_rng;       // almost_full lcg state
    bit          af_on = 0;
    bit          gap_on = 0;
    int          len [0:NUM_EVENTS-1];
    int          total_beats = 0;
    int          limit = 0;    // 0 until worked out
    int          cycles = 0;
    int          model_trigs = 0;
    int          model_events = 0;
    int          cur_width = `WFD_TRIG_WIDTH_DEFAULT;
    logic [31:0] rd;

    always #2 clk125 = ~clk125; // 250 MHz stand-in for clk125

    wfd_top UUT (.*);

    wfd_checker chk (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // single ipbus transfer, returns once the master drops strobe
    task reg_access(input bit wr, input logic [23:0] a, input logic [31:0] d,
                    output logic [31:0] q);
        @(posedge clk125);
        ipb_strobe <= 1'b1;
        ipb_write  <= wr;
        ipb_addr   <= a;
        ipb_wdata  <= d;
        @(negedge clk125);
        while (!ipb_ack) @(negedge clk125);
        q = ipb_rdata; // valid in the ack cycle
        @(posedge clk125);
        ipb_strobe <= 1'b0;
        ipb_write  <= 1'b0;
    endtask

    task reg_write(input logic [23:0] a, input logic [31:0] d);
        reg_access(1'b1, a, d, rd);
    endtask

    task reg_check(input string what, input logic [23:0] a, input logic [31:0] exp);
        reg_access(1'b0, a, 32'd0, rd);
        chk.check_value(what, 66'(exp), 66'(rd));
    endtask

    task set_width(input logic [31:0] w);
        reg_write(`WFD_ADDR_WIDTH, w);
        cur_width = (w[3:0] == 4'd0) ? 1 : int'(w[3:0]); // zero acts as one
        reg_check("WIDTH", `WFD_ADDR_WIDTH, 32'(cur_width));
    endtask

    task send_beats(input int n);
        int          i;
        logic [31:0] cur;
        bit          go;
        i   = 0;
        rng = lcg_next(rng);
        cur = rng;
        while (i < n) begin
            @(posedge clk125);
            rng = lcg_next(rng);
            go  = !(gap_on && rng[31:30] == 2'b00); // one beat in four idles
            chan_rx_valid <= go;
            chan_rx.tdata <= cur;
            chan_rx.tlast <= (i == n - 1);
            @(negedge clk125);
            if (chan_rx_valid && chan_rx_ready) begin
                i++;
                rng = lcg_next(rng);
                cur = rng;
            end
        end
        @(posedge clk125);
        chan_rx_valid <= 1'b0;
        chan_rx.tlast <= 1'b0;
    endtask

    task wait_event_done();
        while (chk.events_seen != model_events) @(posedge clk125);
        while (acq_trigs != '0) @(posedge clk125); // let the pulse finish before next fire
    endtask

    // trigger write, accepted, then the channel answer
    task run_event(input int e);
        chk.arm_trigger(1, cur_width);
        reg_write(`WFD_ADDR_CTRL, 32'd1);
        model_trigs++;
        send_beats(len[e]);
        model_events++;
        wait_event_done();
    endtask

    always @(posedge clk125) begin
        if (reset) begin
            daq_almost_full <= 1'b0;
        end else begin
            af_rng = lcg_next(af_rng);
            daq_almost_full <= af_on & (af_rng[31:30] == 2'b00);
        end
    end

    // run limit
    always @(posedge clk125) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("errors: %0d value, %0d other", chk.value_errors, chk.other_errors);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        reset           = 1'b1;
        ipb_strobe      = 1'b0;
        ipb_write       = 1'b0;
        ipb_addr        = '0;
        ipb_wdata       = '0;
        chan_rx         = '0;
        chan_rx_valid   = 1'b0;
        daq_ready       = 1'b1;
        daq_almost_full = 1'b0;
        rng             = 32'h2e179d9c;
        af_rng          = 32'h2e179d9c ^ 32'h5a5a5a5a;
        for (int e = 0; e < NUM_EVENTS; e++) begin
            rng    = lcg_next(rng);
            len[e] = 1 + int'(rng[31:16] % 9); // 1 to 9 beats
            total_beats += len[e];
        end
        limit = total_beats * 20 + 200 + NUM_EVENTS * 40; // plus register traffic per event

        repeat (4) @(posedge clk125);
        reset <= 1'b0;

        chk.set_test("reset");
        repeat (3) @(posedge clk125);
        reg_check("WIDTH", `WFD_ADDR_WIDTH, 32'd4);
        reg_check("TRIGS", `WFD_ADDR_TRIGS, 32'd0);
        reg_check("EVENTS", `WFD_ADDR_EVENTS, 32'd0);

        chk.set_test("trigger_pulse");
        run_event(0);
        set_width(32'd1);
        run_event(1);
        set_width(32'd15);
        run_event(2);
        set_width(32'd0);
        run_event(3);
        set_width(32'd4);

        chk.set_test("framing");
        for (int e = 4; e < 8; e++) run_event(e);
        reg_check("EVENTS", `WFD_ADDR_EVENTS, 32'(model_events));

        chk.set_test("back_pressure");
        af_on  = 1;
        gap_on = 1;
        for (int e = 8; e < NUM_EVENTS - 1; e++) run_event(e);

        chk.set_test("dropped_busy");
        chk.arm_trigger(1, cur_width);
        reg_write(`WFD_ADDR_CTRL, 32'd1);
        model_trigs++;
        reg_check("STATUS", `WFD_ADDR_STATUS, 32'd3); // busy with link up
        chk.arm_trigger(0, 0);
        reg_write(`WFD_ADDR_CTRL, 32'd1);             // lost, sequencer busy
        model_trigs++;
        reg_check("TRIGS", `WFD_ADDR_TRIGS, 32'(model_trigs));
        reg_check("EVENTS", `WFD_ADDR_EVENTS, 32'(model_events));
        send_beats(len[NUM_EVENTS-1]);
        model_events++;
        wait_event_done();

        chk.set_test("dropped_not_ready");
        @(posedge clk125);
        daq_ready <= 1'b0;
        reg_check("STATUS", `WFD_ADDR_STATUS, 32'd0);
        chk.arm_trigger(0, 0);
        reg_write(`WFD_ADDR_CTRL, 32'd1);
        model_trigs++;
        repeat (20) @(posedge clk125);
        reg_check("TRIGS", `WFD_ADDR_TRIGS, 32'(model_trigs));
        reg_check("EVENTS", `WFD_ADDR_EVENTS, 32'(model_events));
        @(posedge clk125);
        daq_ready <= 1'b1;

        chk.set_test("register_bus");
        reg_check("STATUS", `WFD_ADDR_STATUS, 32'd2);
        reg_check("unmapped", 24'h000010, 32'd0);
        reg_check("EVENTS", `WFD_ADDR_EVENTS, 32'(model_events));
        repeat (5) @(posedge clk125);
        if (chk.nwords != 0) chk.report_problem("an event was never closed by a trailer");

        $display("errors: %0d value, %0d other", chk.value_errors, chk.other_errors);
        if (chk.value_errors + chk.other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
source/wfd_pkg.sv
source/wfd_regs.sv
source/trigger_fanout.sv
source/readout_fsm.sv
source/daq_packer.sv
source/wfd_top.sv
test/wfd_checker.sv
test/tb_wfd_top.sv
